/* bench/tb_tlp_tasks.svh */
/*
 * TRN receive stream drivers for the snooper testbench, included inside
 * the testbench module. Drives on the falling edge, with random gaps and stalls.
 */

////////////////////////////////////////
// bus drivers
////////////////////////////////////////
task automatic idle_bus();
    trn_rd         = '0;
    trn_rrem_n     = 8'hff;
    trn_rsof_n     = 1'b1;
    trn_rsrc_rdy_n = 1'b1;
    trn_reof_n     = 1'b1;
    trn_rsrc_dsc_n = 1'b1;
    trn_rbar_hit_n = 7'h7f;                 // no BAR hit
    trn_rdst_rdy_n = 1'b0;                  // sink ready by default
endtask

// one beat; returns on the falling edge after it transferred
task automatic send_beat(input trn_data_t data, input logic sof, input logic eof,
                         input logic [7:0] rrem_n, input logic dsc,
                         input logic [6:0] bar_hit_n, input bit quiet);
    int gaps;
    int stalls;
    gaps   = quiet ? 0 : int'(rand_bits(2));    // source idle cycles
    stalls = quiet ? 0 : int'(rand_bits(2));    // sink not ready cycles
    trn_rsrc_rdy_n = 1'b1;
    repeat (gaps) @(negedge trn_clk);
    trn_rd         = data;
    trn_rsof_n     = !sof;
    trn_reof_n     = !eof;
    trn_rrem_n     = rrem_n;
    trn_rsrc_dsc_n = !dsc;
    trn_rbar_hit_n = bar_hit_n;
    trn_rsrc_rdy_n = 1'b0;
    trn_rdst_rdy_n = 1'b1;
    repeat (stalls) @(negedge trn_clk);
    trn_rdst_rdy_n = 1'b0;
    @(negedge trn_clk);                     // beat taken on this posedge
    trn_rsrc_rdy_n = 1'b1;
    trn_rsof_n     = 1'b1;
    trn_reof_n     = 1'b1;
    trn_rsrc_dsc_n = 1'b1;
endtask

// header beat, address beat, data beat; dsc marks the final beat
task automatic send_tlp(input bit is64, input fmt_type_t fmt, input logic [9:0] len,
                        input logic [6:0] bar_hit_n, input reg_offset_t offs,
                        input logic [31:0] dw0, input logic [31:0] dw1,
                        input bit dsc, input bit quiet);
    trn_data_t hdr;
    trn_data_t addr;
    trn_data_t data;
    hdr = {1'b0, fmt, 14'h0, len, 32'h0100_00ff};       // req id, tag, byte enables
    if (is64) begin
        addr = {32'h0000_0001, 24'hc0_0000, offs, 2'b00};
        data = {dw0, dw1};                              // both dwords, dw0 upper
    end else begin
        addr = {24'hc0_0000, offs, 2'b00, dw0};         // dw0 rides with address
        data = {dw1, 32'h0};
    end
    send_beat(hdr, 1'b1, 1'b0, 8'h00, 1'b0, bar_hit_n, quiet);
    send_beat(addr, 1'b0, 1'b0, 8'h00, 1'b0, bar_hit_n, quiet);
    send_beat(data, 1'b0, 1'b1, is64 ? 8'h00 : 8'h0f, dsc, bar_hit_n, quiet);
    trn_rbar_hit_n = 7'h7f;
endtask

/* bench/tb_host_synch.sv */
/*
 * Testbench for host_synch_top: random BAR2 write TLPs checked against a
 * byte-swap model, then interrupt holdoff, handshake and re-arm sequences.
 */
`default_nettype none
`include "host_synch_settings.svh"

module tb_host_synch;
    import host_synch_pkg::*;

    localparam int N_TLP       = 60;
    localparam int BEAT_CYC    = 3 + 3 + 1;             // max gap + max stall + beat
    localparam int CYCLE_LIMIT = (N_TLP + 8) * 3 * BEAT_CYC + 8 * (`INTR_HOLDOFF + 24);

    logic      trn_clk = 1'b0;
    logic      reset;
    trn_data_t trn_rd;
    logic [7:0] trn_rrem_n;
    logic      trn_rsof_n;
    logic      trn_reof_n;
    logic      trn_rsrc_rdy_n;
    logic      trn_rsrc_dsc_n;
    logic      trn_rdst_rdy_n;
    logic [6:0] trn_rbar_hit_n;
    pointer_t  hw_pointer;
    pointer_t  sw_pointer;
    logic      intr_ready;
    logic      intr_enable;
    logic      intr_valid;
    logic [31:0] lfsr_state;
    pointer_t  model_sw;                                // expected sw_pointer
    logic      model_en;                                // expected intr_enable
    int        cycles = 0;
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    int        test_errs;
    string     test_name;

    host_synch_top u_dut (.*);

    always #5 trn_clk = ~trn_clk;

    always @(posedge trn_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // taps 32,22,2,1; one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] host_to_dev(input logic [31:0] dw);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = dw[8*(3-b) +: 8];             // byte b from byte 3-b
        end
        return r;
    endfunction

    `include "tb_tlp_tasks.svh"

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %0d %s %s", tests, test_name, (errors == test_errs) ? "ok" : "FAILED");
    endtask

    // send, then check old value after last beat and new value one cycle later
    task automatic tlp_and_check(input bit is64, input fmt_type_t fmt, input logic [9:0] len,
                                 input logic [6:0] bar_hit_n, input reg_offset_t offs,
                                 input logic [31:0] dw0, input logic [31:0] dw1,
                                 input bit dsc, input bit accept, input bit quiet,
                                 input bit track_hw);
        logic [31:0] ctrl_dev;                          // control dword, device order
        send_tlp(is64, fmt, len, bar_hit_n, offs, dw0, dw1, dsc, quiet);
        check({test_name, " sw_pointer early"}, model_sw, sw_pointer);
        ctrl_dev = host_to_dev(dw0);
        if (accept && offs == `SW_PTR_OFFSET) model_sw = {host_to_dev(dw1), host_to_dev(dw0)};
        if (accept && offs == `CTRL_OFFSET) model_en = ctrl_dev[0];
        @(negedge trn_clk);
        check({test_name, " sw_pointer"}, model_sw, sw_pointer);
        check({test_name, " intr_enable"}, 64'(model_en), 64'(intr_enable));
        if (track_hw) hw_pointer = model_sw;            // keep pointers in step
    endtask

    task automatic run_random_tlp();
        bit          is64;
        fmt_type_t   fmt;
        logic [9:0]  len;
        logic [6:0]  bar_n;
        reg_offset_t offs;
        int          kind;
        int          sel;
        bit          dsc;
        bit          accept;
        kind   = int'(rand_bits(3));
        is64   = bit'(rand_bits(1));
        fmt    = is64 ? `MEM_WR64_FMT_TYPE : `MEM_WR32_FMT_TYPE;
        len    = `PAYLOAD_DW;
        bar_n  = 7'h7b;                                 // BAR2 only
        offs   = `SW_PTR_OFFSET;
        dsc    = 1'b0;
        accept = 1'b0;
        case (kind)
            0, 1, 2, 3: begin
                accept = 1'b1;
                begin_test(is64 ? "sw_ptr_write64" : "sw_ptr_write32");
            end
            4: begin
                accept = 1'b1;
                offs   = `CTRL_OFFSET;
                begin_test("ctrl_write");
            end
            5: begin
                sel   = int'(rand_bits(2));
                bar_n = 7'h7f & ~(7'h01 << ((sel < 2) ? sel : sel + 1));
                begin_test("other_bar");
            end
            6: begin
                offs = reg_offset_t'(rand_bits(6));
                if (offs == `SW_PTR_OFFSET || offs == `CTRL_OFFSET) offs = 6'h3f;
                begin_test("other_offset");
            end
            default: begin
                sel = int'(rand_bits(2));
                if (sel == 0) begin
                    len = 10'(rand_bits(10));
                    if (len == `PAYLOAD_DW) len = 10'd3;
                    begin_test("bad_length");
                end else if (sel == 1) begin
                    fmt = is64 ? 7'b01_00000 : 7'b10_01010;     // MRd64 or CplD
                    begin_test("non_write");
                end else begin
                    dsc = 1'b1;
                    begin_test("discontinue");
                end
            end
        endcase
        tlp_and_check(is64, fmt, len, bar_n, offs, 32'(rand_bits(32)), 32'(rand_bits(32)),
                      dsc, accept, 1'b0, 1'b1);
        check({test_name, " intr_valid"}, 64'd0, 64'(intr_valid));
        end_test();
    endtask

    task automatic expect_intr(input int n, input logic level);
        repeat (n) begin
            @(negedge trn_clk);
            check({test_name, " intr_valid"}, 64'(level), 64'(intr_valid));
        end
    endtask

    initial begin
        int n;
        lfsr_state = 32'h564a_dcc8;
        reset      = 1'b1;
        hw_pointer = '0;
        intr_ready = 1'b0;
        model_sw   = '0;
        model_en   = 1'b0;
        idle_bus();
        repeat (4) @(negedge trn_clk);
        reset = 1'b0;
        begin_test("reset_values");
        check("reset sw_pointer", 64'd0, sw_pointer);
        check("reset intr_enable", 64'd0, 64'(intr_enable));
        expect_intr(1, 1'b0);
        end_test();
        repeat (N_TLP) run_random_tlp();

        ////////////////////////////////////////
        // interrupt sequences
        ////////////////////////////////////////
        begin_test("intr_holdoff");
        tlp_and_check(1'b0, `MEM_WR32_FMT_TYPE, `PAYLOAD_DW, 7'h7b, `CTRL_OFFSET,
                      32'h0100_0000, 32'h0, 1'b0, 1'b1, 1'b1, 1'b1);
        hw_pointer = model_sw ^ (rand_bits(64) | 64'h1);    // mismatch starts now
        expect_intr(`INTR_HOLDOFF, 1'b0);
        expect_intr(1, 1'b1);
        n = 1 + int'(rand_bits(4));
        expect_intr(n, 1'b1);                           // held while ready low
        intr_ready = 1'b1;
        expect_intr(1, 1'b0);
        intr_ready = 1'b0;
        end_test();
        begin_test("intr_disarmed");
        expect_intr(`INTR_HOLDOFF + 4, 1'b0);
        end_test();
        begin_test("intr_rearm");
        tlp_and_check(1'b1, `MEM_WR64_FMT_TYPE, `PAYLOAD_DW, 7'h7b, `SW_PTR_OFFSET,
                      32'(rand_bits(32)), 32'(rand_bits(32)), 1'b0, 1'b1, 1'b1, 1'b0);
        if (hw_pointer == model_sw) hw_pointer = ~model_sw;
        n = 0;
        while (!intr_valid && n < `INTR_HOLDOFF + 8) begin
            @(negedge trn_clk);
            n++;
        end
        if (!intr_valid) begin
            errors++;
            $display("intr_rearm: no interrupt request after a new software pointer");
        end
        intr_ready = 1'b1;
        expect_intr(1, 1'b0);
        intr_ready = 1'b0;
        end_test();
        begin_test("intr_cancel_equal");
        tlp_and_check(1'b0, `MEM_WR32_FMT_TYPE, `PAYLOAD_DW, 7'h7b, `SW_PTR_OFFSET,
                      32'(rand_bits(32)), 32'(rand_bits(32)), 1'b0, 1'b1, 1'b1, 1'b0);
        if (hw_pointer == model_sw) hw_pointer = ~model_sw;
        expect_intr(`INTR_HOLDOFF / 2, 1'b0);           // re-armed, holdoff running
        hw_pointer = model_sw;                          // back in step mid holdoff
        expect_intr(`INTR_HOLDOFF + 4, 1'b0);
        end_test();
        begin_test("intr_cancel_disable");
        hw_pointer = ~model_sw;                         // armed and enabled, counting
        tlp_and_check(1'b0, `MEM_WR32_FMT_TYPE, `PAYLOAD_DW, 7'h7b, `CTRL_OFFSET,
                      32'h0, 32'h0, 1'b0, 1'b1, 1'b1, 1'b0);
        expect_intr(`INTR_HOLDOFF + 4, 1'b0);
        end_test();

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the snooper testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_host_synch -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0

/* tb.f */
+incdir+verilog
+incdir+bench
verilog/host_synch_pkg.sv
verilog/mem_wr_decoder.sv
verilog/pointer_regs.sv
verilog/synch_intr_gen.sv
verilog/host_synch_top.sv
bench/tb_host_synch.sv

/* verilog/host_synch_pkg.sv */
/*
 * Types for the host pointer snooper: TRN beat, ring pointer, TLP fmt/type
 * and BAR2 dword offset. Modules import it inside their bodies.
 */
`default_nettype none

package host_synch_pkg;

    // one beat of the 64-bit TRN receive stream
    // header dword 0 sits in [63:32], dword 1 in [31:0]
    typedef logic [63:0] trn_data_t;

    // ring pointer, device byte order
    // low half is payload dword 0 after byte reversal
    typedef logic [63:0] pointer_t;

    // fmt[1:0] and type[4:0] of a TLP header, bits 30:24 of dword 0
    typedef logic [6:0] fmt_type_t;

    // dword offset within BAR2, address bits 7:2
    typedef logic [5:0] reg_offset_t;

endpackage

`default_nettype wire

/* verilog/host_synch_settings.svh */
/*
 * Constants shared by the host pointer snooper and its testbench.
 * Include after `default_nettype and before the module that uses them.
 */
`ifndef HOST_SYNCH_SETTINGS_SVH
`define HOST_SYNCH_SETTINGS_SVH

////////////////////////////////////////
// TLP header codes
////////////////////////////////////////
`define MEM_WR32_FMT_TYPE 7'b10_00000   // 3DW header, with data, MWr
`define MEM_WR64_FMT_TYPE 7'b11_00000   // 4DW header, with data, MWr
`define PAYLOAD_DW        10'd2         // length field, one 64-bit pointer

////////////////////////////////////////
// BAR2 register map
////////////////////////////////////////
`define SYNCH_BAR         2             // index into trn_rbar_hit_n
`define SW_PTR_OFFSET     6'd0          // dword offset, software pointer
`define CTRL_OFFSET       6'd2          // dword offset, control (bit 0 = intr enable)

// cycles a pointer mismatch must last before an interrupt request
`define INTR_HOLDOFF      16

`endif

/* verilog/host_synch_top.sv */
/*
 * Host pointer snooper top: decoder, BAR2 registers and interrupt generator.
 * Sits beside the real TRN receive sink and only observes the stream.
 */
`default_nettype none

module host_synch_top (
    input  wire                         trn_clk,
    input  wire                         reset,
    input  wire host_synch_pkg::trn_data_t trn_rd,
    input  wire [7:0]                   trn_rrem_n,
    input  wire                         trn_rsof_n,
    input  wire                         trn_reof_n,
    input  wire                         trn_rsrc_rdy_n,
    input  wire                         trn_rsrc_dsc_n,
    input  wire [6:0]                   trn_rbar_hit_n,
    input  wire                         trn_rdst_rdy_n,
    input  wire host_synch_pkg::pointer_t hw_pointer,
    input  wire                         intr_ready,
    output host_synch_pkg::pointer_t    sw_pointer,
    output logic                        intr_enable,
    output logic                        intr_valid
);
    import host_synch_pkg::*;

    logic        wr_valid;              // decoded register write strobe
    reg_offset_t wr_offset;
    pointer_t    wr_data;               // already in device byte order
    logic        sw_ptr_wr;             // pointer register written

    mem_wr_decoder u_decoder (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rrem_n     (trn_rrem_n),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rsrc_dsc_n (trn_rsrc_dsc_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .trn_rdst_rdy_n (trn_rdst_rdy_n),
        .wr_valid       (wr_valid),
        .wr_offset      (wr_offset),
        .wr_data        (wr_data)
    );

    pointer_regs u_regs (
        .trn_clk     (trn_clk),
        .reset       (reset),
        .wr_valid    (wr_valid),
        .wr_offset   (wr_offset),
        .wr_data     (wr_data),
        .sw_pointer  (sw_pointer),
        .intr_enable (intr_enable),
        .sw_ptr_wr   (sw_ptr_wr)
    );

    synch_intr_gen u_intr_gen (
        .trn_clk     (trn_clk),
        .reset       (reset),
        .hw_pointer  (hw_pointer),
        .sw_pointer  (sw_pointer),
        .intr_enable (intr_enable),
        .sw_ptr_wr   (sw_ptr_wr),
        .intr_ready  (intr_ready),
        .intr_valid  (intr_valid)
    );

endmodule

`default_nettype wire

/* verilog/mem_wr_decoder.sv */
/*
 * Snoops the TRN receive stream for 3DW/4DW memory writes to BAR2 with a
 * two-dword payload and emits one byte-swapped register write per TLP.
 * Never drives trn_rdst_rdy_n, so it only sees beats the real sink accepts.
 */
`default_nettype none
`include "host_synch_settings.svh"

module mem_wr_decoder (
    input  wire                         trn_clk,
    input  wire                         reset,
    input  wire host_synch_pkg::trn_data_t trn_rd,
    input  wire [7:0]                   trn_rrem_n,
    input  wire                         trn_rsof_n,
    input  wire                         trn_reof_n,
    input  wire                         trn_rsrc_rdy_n,
    input  wire                         trn_rsrc_dsc_n,
    input  wire [6:0]                   trn_rbar_hit_n,
    input  wire                         trn_rdst_rdy_n,
    output logic                        wr_valid,
    output host_synch_pkg::reg_offset_t wr_offset,
    output host_synch_pkg::pointer_t    wr_data
);
    import host_synch_pkg::*;

    typedef enum logic [4:0] {
        idle   = 5'b00001,              // waiting for sof
        addr32 = 5'b00010,              // 3DW address beat, carries dw0
        data32 = 5'b00100,              // 3DW last beat, dw1 in upper half
        addr64 = 5'b01000,              // 4DW address beat
        data64 = 5'b10000               // 4DW last beat, both dwords
    } state_t;

    state_t      state;
    fmt_type_t   fmt_type;              // header fmt/type field
    logic        xfer;                  // beat accepted by the sink
    logic        abort;                 // discontinue from source
    logic        hdr_hit;               // sof beat on BAR2, 2DW payload
    logic        last32_ok;             // clean end of a 3DW write
    logic        last64_ok;             // clean end of a 4DW write
    reg_offset_t offs;                  // held between address and data beat
    logic [31:0] dw0_swap;              // 3DW payload dw0, already swapped

    // host sends dwords big end first on the wire
    function automatic logic [31:0] byte_swap(input logic [31:0] dw);
        byte_swap = {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign xfer      = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;
    assign abort     = !trn_rsrc_dsc_n;
    assign fmt_type  = trn_rd[62:56];
    assign hdr_hit   = !trn_rsof_n && !trn_rbar_hit_n[`SYNCH_BAR] &&
                       (trn_rd[41:32] == `PAYLOAD_DW);      // length field
    assign last32_ok = !trn_reof_n && !trn_rrem_n[4];       // upper dword valid
    assign last64_ok = !trn_reof_n && (trn_rrem_n == 8'h00); // full beat

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state    <= idle;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;                           // strobe
            if (abort) begin
                state <= idle;                          // drop partial TLP
            end else if (xfer) begin
                case (state)
                    idle: begin
                        if (hdr_hit && fmt_type == `MEM_WR32_FMT_TYPE) begin
                            state <= addr32;
                        end else if (hdr_hit && fmt_type == `MEM_WR64_FMT_TYPE) begin
                            state <= addr64;
                        end                             // others skipped till next sof
                    end
                    addr32: state <= trn_reof_n ? data32 : idle;    // early eof
                    addr64: state <= trn_reof_n ? data64 : idle;
                    data32: begin
                        state    <= idle;
                        wr_valid <= last32_ok;
                    end
                    data64: begin
                        state    <= idle;
                        wr_valid <= last64_ok;
                    end
                    default: state <= idle;             // illegal one-hot
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // offset and payload capture
    ////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (xfer) begin
            case (state)
                addr32: begin
                    offs     <= trn_rd[39:34];          // addr bits 7:2 of dw2
                    dw0_swap <= byte_swap(trn_rd[31:0]);
                end
                addr64: offs <= trn_rd[7:2];            // low addr dword
                data32: begin
                    wr_offset <= offs;
                    wr_data   <= {byte_swap(trn_rd[63:32]), dw0_swap};
                end
                data64: begin
                    wr_offset <= offs;
                    wr_data   <= {byte_swap(trn_rd[31:0]), byte_swap(trn_rd[63:32])};
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/pointer_regs.sv */
/*
 * BAR2 register block: software ring pointer and control register.
 * Written only by the decoder; writes to unmapped offsets are dropped.
 */
`default_nettype none
`include "host_synch_settings.svh"

module pointer_regs (
    input  wire                         trn_clk,
    input  wire                         reset,
    input  wire                         wr_valid,
    input  wire host_synch_pkg::reg_offset_t wr_offset,
    input  wire host_synch_pkg::pointer_t wr_data,
    output host_synch_pkg::pointer_t    sw_pointer,
    output logic                        intr_enable,
    output logic                        sw_ptr_wr
);
    import host_synch_pkg::*;

    localparam reg_offset_t sw_ptr_offs = `SW_PTR_OFFSET;
    localparam reg_offset_t ctrl_offs   = `CTRL_OFFSET;

    logic sel_sw_ptr;                   // write hits pointer register
    logic sel_ctrl;                     // write hits control register

    assign sel_sw_ptr = wr_valid && (wr_offset == sw_ptr_offs);
    assign sel_ctrl   = wr_valid && (wr_offset == ctrl_offs);

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            sw_pointer  <= '0;
            intr_enable <= 1'b0;
            sw_ptr_wr   <= 1'b0;
        end else begin
            sw_ptr_wr <= sel_sw_ptr;                    // lines up with new value
            if (sel_sw_ptr) begin
                sw_pointer <= wr_data;                  // full 64 bits at once
            end
            if (sel_ctrl) begin
                intr_enable <= wr_data[0];              // other bits reserved
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/synch_intr_gen.sv */
/*
 * Raises an interrupt request when the hardware and software pointers stay
 * apart for the holdoff time. One request per software pointer update.
 */
`default_nettype none
`include "host_synch_settings.svh"

module synch_intr_gen (
    input  wire                         trn_clk,
    input  wire                         reset,
    input  wire host_synch_pkg::pointer_t hw_pointer,
    input  wire host_synch_pkg::pointer_t sw_pointer,
    input  wire                         intr_enable,
    input  wire                         sw_ptr_wr,
    input  wire                         intr_ready,
    output logic                        intr_valid
);

    localparam int unsigned holdoff = `INTR_HOLDOFF;
    localparam int unsigned cnt_w   = $clog2(holdoff + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(holdoff);

    logic [cnt_w-1:0] holdoff_cnt;      // cycles of continuous mismatch
    logic             armed;            // cleared after a served request
    logic             out_of_step;      // pointers differ, may count
    logic             fire;             // holdoff expired this cycle
    logic             handshake;        // request taken by the sink

    assign out_of_step = intr_enable && armed && !intr_valid &&
                         (hw_pointer != sw_pointer);
    assign fire        = out_of_step && (holdoff_cnt == cnt_max);
    assign handshake   = intr_valid && intr_ready;

    ////////////////////////////////////////
    // holdoff counter
    ////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            holdoff_cnt <= '0;
        end else if (!out_of_step) begin
            holdoff_cnt <= '0;                          // any gap restarts
        end else if (holdoff_cnt != cnt_max) begin
            holdoff_cnt <= holdoff_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // arm flag and request
    ////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            armed      <= 1'b1;                         // first mismatch may fire
            intr_valid <= 1'b0;
        end else begin
            if (sw_ptr_wr) begin
                armed <= 1'b1;                          // fresh update re-arms
            end else if (handshake) begin
                armed <= 1'b0;
            end

            if (handshake) begin
                intr_valid <= 1'b0;
            end else if (fire) begin
                intr_valid <= 1'b1;                     // held until ready
            end
        end
    end

endmodule

`default_nettype wire
